/* Makefile */
TOP = tb_vic_registers

.PHONY: compile run clean

compile:
	verilator --binary --timing -j 0 --top-module $(TOP) -f filelist.f -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

/* filelist.f */
+incdir+verif
logic/vic_regs_pkg.sv
logic/bus_timing.sv
logic/display_ctrl_regs.sv
logic/color_regs.sv
logic/irq_ctrl_regs.sv
logic/reg_read_mux.sv
logic/vic_registers.sv
verif/tb_vic_registers.sv

/* verif/tb_vic_registers_table.svh */
`ifndef TB_VIC_REGISTERS_TABLE_SVH
`define TB_VIC_REGISTERS_TABLE_SVH

// one row per step with name, operation, address, data, keep mask and fixed bits
// inputs stay at raster_line 0x1a5, lpx 0x3c, lpy 0xc3 and status bits reading 0xf5
task automatic load_steps();
        add_step("reset_ctrl1", OP_RD, 6'h11, 8'h00, 8'h00, 8'h80);
        add_step("reset_raster", OP_RD, 6'h12, 8'h00, 8'h00, 8'ha5);
        add_step("reset_lpx", OP_RD, 6'h13, 8'h00, 8'h00, 8'h3c);
        add_step("reset_lpy", OP_RD, 6'h14, 8'h00, 8'h00, 8'hc3);
        add_step("reset_ctrl2", OP_RD, 6'h16, 8'h00, 8'h00, 8'hc0);
        add_step("reset_mem", OP_RD, 6'h18, 8'h00, 8'h00, 8'h01);
        add_step("reset_irq_status", OP_RD, 6'h19, 8'h00, 8'h00, 8'hf5);
        add_step("reset_irq_ctrl", OP_RD, 6'h1a, 8'h00, 8'h00, 8'hf0);
        add_step("reset_border", OP_RD, 6'h20, 8'h00, 8'h00, 8'hf0);
        add_step("reset_bg3", OP_RD, 6'h24, 8'h00, 8'h00, 8'hf0);
        add_step("unmapped_read", OP_RD, 6'h3f, 8'h00, 8'h00, 8'hff);
        add_step("ctrl1_write", OP_WR_RND, 6'h11, 8'h00, 8'h00, 8'h00);
        add_step("ctrl1_read", OP_RD, 6'h11, 8'h00, 8'h7f, 8'h80);
        add_step("ctrl2_write", OP_WR_RND, 6'h16, 8'h00, 8'h00, 8'h00);
        add_step("ctrl2_read", OP_RD, 6'h16, 8'h00, 8'h3f, 8'hc0);
        add_step("mem_write", OP_WR_RND, 6'h18, 8'h00, 8'h00, 8'h00);
        add_step("mem_read", OP_RD, 6'h18, 8'h00, 8'hfe, 8'h01);
        add_step("raster_cmp_write", OP_WR_RND, 6'h12, 8'h00, 8'h00, 8'h00);
        add_step("raster_read", OP_RD, 6'h12, 8'h00, 8'h00, 8'ha5);
        add_step("border_write", OP_WR, 6'h20, 8'h37, 8'h00, 8'h00);
        add_step("border_read", OP_RD, 6'h20, 8'h00, 8'h00, 8'hf7);
        add_step("bg0_write", OP_WR_RND, 6'h21, 8'h00, 8'h00, 8'h00);
        add_step("bg0_read", OP_RD, 6'h21, 8'h00, 8'h0f, 8'hf0);
        add_step("bg1_write", OP_WR_RND, 6'h22, 8'h00, 8'h00, 8'h00);
        add_step("bg1_read", OP_RD, 6'h22, 8'h00, 8'h0f, 8'hf0);
        add_step("bg2_write", OP_WR_RND, 6'h23, 8'h00, 8'h00, 8'h00);
        add_step("bg2_read", OP_RD, 6'h23, 8'h00, 8'h0f, 8'hf0);
        add_step("bg3_write", OP_WR_RND, 6'h24, 8'h00, 8'h00, 8'h00);
        add_step("bg3_read", OP_RD, 6'h24, 8'h00, 8'h0f, 8'hf0);
        add_step("irq_ctrl_write", OP_WR_RND, 6'h1a, 8'h00, 8'h00, 8'h00);
        add_step("irq_ctrl_read", OP_RD, 6'h1a, 8'h00, 8'h0f, 8'hf0);
        add_step("irq_clear", OP_PULSE, 6'h19, 8'h0f, 8'h00, 8'h00);
        add_step("irq_status_read", OP_RD, 6'h19, 8'h00, 8'h00, 8'hf5);
        add_step("write_ab_high", OP_WR_AB, 6'h20, 8'h0a, 8'h00, 8'h00);
        add_step("border_after_ab", OP_RD, 6'h20, 8'h00, 8'h00, 8'hf7);
        add_step("write_short", OP_WR_SHORT, 6'h20, 8'h0c, 8'h00, 8'h00);
        add_step("border_after_short", OP_RD, 6'h20, 8'h00, 8'h00, 8'hf7);
endtask

`endif

/* verif/tb_vic_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_vic_registers;

        localparam int DAV_TICK = 28;
        localparam int PHI_TICKS = vic_regs_pkg::PHASE_TICKS;
        // late start inside the high phase, still before the data strobe tick
        localparam int SHORT_START = PHI_TICKS / 2 + 4;

        typedef enum logic [2:0] {
                OP_WR, OP_WR_RND, OP_WR_AB, OP_WR_SHORT, OP_RD, OP_PULSE
        } op_t;

        // expected read is the last accepted write masked by keep, or'ed with exp
        typedef struct packed {
                op_t                 op;
                logic [5:0]          addr;
                vic_regs_pkg::data_t data;
                vic_regs_pkg::data_t keep;
                vic_regs_pkg::data_t exp;
        } step_t;

        logic clk_dot4x = 1'b0;
        logic rst;
        logic ce;
        logic rw;
        logic vic_write_ab;
        vic_regs_pkg::reg_addr_t adi;
        vic_regs_pkg::data_t dbi;
        vic_regs_pkg::raster_t raster_line;
        vic_regs_pkg::data_t lpx;
        vic_regs_pkg::data_t lpy;
        logic irq, ilp, immc, imbc, irst;
        logic clk_phi;
        logic phase_15;
        vic_regs_pkg::data_t dbo;
        vic_regs_pkg::vic_color_t ec;
        vic_regs_pkg::vic_color_t bg_color [vic_regs_pkg::NUM_BG_COLORS];
        logic [2:0] xscroll, yscroll, cb;
        logic csel, rsel, den, bmm, ecm, res, mcm;
        vic_regs_pkg::raster_t raster_irq_compare;
        logic [3:0] vm;
        logic irst_clr, imbc_clr, immc_clr, ilp_clr;
        logic erst, embc, emmc, elp;

        step_t steps[$];
        string step_names[$];
        logic [31:0] lfsr_state = 32'h293;
        vic_regs_pkg::data_t wr_val;

        vic_registers #(.dav_tick(DAV_TICK)) u_vic_registers (.*);

        always #4 clk_dot4x = ~clk_dot4x;

        task automatic add_step(input string name, input op_t op, input logic [5:0] addr,
                        input vic_regs_pkg::data_t data, input vic_regs_pkg::data_t keep,
                        input vic_regs_pkg::data_t exp);
                steps.push_back(step_t'{op, addr, data, keep, exp});
                step_names.push_back(name);
        endtask

        // fibonacci taps 32 22 2 1
        function automatic logic [31:0] lfsr_step(input logic [31:0] s);
                return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
        endfunction

        function automatic vic_regs_pkg::data_t rand_byte();
                vic_regs_pkg::data_t b;
                b = '0;
                for (int i = 0; i < 8; i++) begin
                        lfsr_state = lfsr_step(lfsr_state);
                        b = {b[6:0], lfsr_state[0]};
                end
                return b;
        endfunction

        task automatic fail_run(input string msg);
                $display("%s", msg);
                $display("TESTBENCH FAILED");
                $fatal(1, "simulation stopped");
        endtask

        task automatic check_data(input string name, input vic_regs_pkg::data_t exp,
                        input vic_regs_pkg::data_t act);
                if (act !== exp) begin
                        fail_run($sformatf("Error: %s expected 0x%h actual 0x%h", name, exp, act));
                end
        endtask

        task automatic check_color(input string name, input vic_regs_pkg::vic_color_t exp,
                        input vic_regs_pkg::vic_color_t act);
                if (act !== exp) begin
                        fail_run($sformatf("Error: %s expected %s actual %s",
                                           name, exp.name(), act.name()));
                end
        endtask

        task automatic check_flag(input string name, input bit exp, input logic act);
                if (act !== exp) begin
                        fail_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
                end
        endtask

        // returns on the negedge right after phi goes high, i.e. in tick 16
        task automatic wait_phi_rise();
                logic prev;
                logic prev_p15;
                int n;
                n = 0;
                @(negedge clk_dot4x);
                prev = clk_phi;
                prev_p15 = phase_15;
                @(negedge clk_dot4x);
                while (prev || !clk_phi) begin
                        if (n == 2 * PHI_TICKS) begin
                                fail_run("timeout while waiting for phi to rise");
                        end
                        prev = clk_phi;
                        prev_p15 = phase_15;
                        n++;
                        @(negedge clk_dot4x);
                end
                // strobe on the last low tick only
                check_flag("phase_15_tick_15", 1'b1, prev_p15);
                check_flag("phase_15_tick_16", 1'b0, phase_15);
        endtask

        task automatic bus_write(input logic [5:0] addr, input vic_regs_pkg::data_t data,
                        input int start, input int hold, input logic ab);
                wait_phi_rise();
                // rest of this phi cycle, so the access starts on tick 0 plus start
                repeat (PHI_TICKS / 2 + start) @(posedge clk_dot4x);
                adi <= vic_regs_pkg::reg_addr_t'(addr);
                dbi <= data;
                vic_write_ab <= ab;
                ce <= 1'b0;
                rw <= 1'b0;
                repeat (hold) @(posedge clk_dot4x);
                ce <= 1'b1;
                rw <= 1'b1;
                vic_write_ab <= 1'b0;
                @(negedge clk_dot4x);
        endtask

        task automatic bus_read(input string name, input logic [5:0] addr,
                        input vic_regs_pkg::data_t exp);
                @(posedge clk_dot4x);
                adi <= vic_regs_pkg::reg_addr_t'(addr);
                ce <= 1'b0;
                rw <= 1'b1;
                repeat (2) @(posedge clk_dot4x);
                ce <= 1'b1;
                @(negedge clk_dot4x);
                check_data(name, exp, dbo);
        endtask

        task automatic check_write_effect(input string name, input logic [5:0] addr);
                case (addr)
                        6'h11: begin
                                check_flag(name, wr_val[7], raster_irq_compare[8]);
                                check_data(name, {1'b0, wr_val[6:0]},
                                           {1'b0, ecm, bmm, den, rsel, yscroll});
                        end
                        6'h12: check_data(name, wr_val, raster_irq_compare[7:0]);
                        6'h16: check_data(name, {2'b00, wr_val[5:0]},
                                          {2'b00, res, mcm, csel, xscroll});
                        6'h18: check_data(name, {wr_val[7:1], 1'b0}, {vm, cb, 1'b0});
                        6'h1a: check_data(name, {4'h0, wr_val[3:0]}, {4'h0, elp, emmc, embc, erst});
                        6'h20: check_color(name, vic_regs_pkg::vic_color_t'(wr_val[3:0]), ec);
                        6'h21, 6'h22, 6'h23, 6'h24:
                                check_color(name, vic_regs_pkg::vic_color_t'(wr_val[3:0]),
                                            bg_color[2'(addr - 6'h21)]);
                        default: ;
                endcase
        endtask

        task automatic check_clear_pulse(input string name, input logic [5:0] addr,
                        input vic_regs_pkg::data_t data);
                int n;
                // release right after the data strobe tick
                bus_write(addr, data, 0, DAV_TICK + 1, 1'b0);
                check_data(name, {4'h0, data[3:0]},
                           {4'h0, ilp_clr, immc_clr, imbc_clr, irst_clr});
                n = 0;
                while (irst_clr) begin
                        if (n == PHI_TICKS) begin
                                fail_run("irst_clr stayed high for more than one phi cycle");
                        end
                        n++;
                        @(negedge clk_dot4x);
                end
        endtask

        `include "tb_vic_registers_table.svh"

        initial begin
                step_t st;
                rst <= 1'b1;
                ce <= 1'b1;
                rw <= 1'b1;
                vic_write_ab <= 1'b0;
                adi <= vic_regs_pkg::REG_SCREEN_CONTROL_1;
                dbi <= '0;
                raster_line <= 9'h1a5;
                lpx <= 8'h3c;
                lpy <= 8'hc3;
                irq <= 1'b1;
                ilp <= 1'b0;
                immc <= 1'b1;
                imbc <= 1'b0;
                irst <= 1'b1;
                wr_val = '0;
                load_steps();
                repeat (8) @(posedge clk_dot4x);
                rst <= 1'b0;
                for (int i = 0; i < steps.size(); i++) begin
                        st = steps[i];
                        case (st.op)
                                OP_WR, OP_WR_RND: begin
                                        if (st.op == OP_WR_RND) begin
                                                wr_val = rand_byte();
                                        end else begin
                                                wr_val = st.data;
                                        end
                                        bus_write(st.addr, wr_val, 0, PHI_TICKS, 1'b0);
                                        check_write_effect(step_names[i], st.addr);
                                end
                                OP_WR_AB: bus_write(st.addr, st.data, 0, PHI_TICKS, 1'b1);
                                OP_WR_SHORT: bus_write(st.addr, st.data, SHORT_START,
                                                       PHI_TICKS - SHORT_START, 1'b0);
                                OP_RD: bus_read(step_names[i], st.addr, (wr_val & st.keep) | st.exp);
                                OP_PULSE: check_clear_pulse(step_names[i], st.addr, st.data);
                                default: fail_run("unknown operation in the step table");
                        endcase
                end
                $display("TESTBENCH PASSED");
                $finish;
        end

endmodule

`default_nettype wire

/* logic/vic_registers.sv */
`timescale 1ns/1ps
`default_nettype none

module vic_registers #(
        parameter int dav_tick = 28
) (
        input  wire                        clk_dot4x,
        input  wire                        rst,
        input  wire                        ce,
        input  wire                        rw,
        input  wire                        vic_write_ab,
        input  vic_regs_pkg::reg_addr_t    adi,
        input  vic_regs_pkg::data_t        dbi,
        input  vic_regs_pkg::raster_t      raster_line,
        input  vic_regs_pkg::data_t        lpx,
        input  vic_regs_pkg::data_t        lpy,
        input  wire                        irq,
        input  wire                        ilp,
        input  wire                        immc,
        input  wire                        imbc,
        input  wire                        irst,
        output logic                       clk_phi,
        output logic                       phase_15,
        output vic_regs_pkg::data_t        dbo,
        output vic_regs_pkg::vic_color_t   ec,
        output vic_regs_pkg::vic_color_t   bg_color [vic_regs_pkg::NUM_BG_COLORS],
        output logic [2:0]                 xscroll,
        output logic [2:0]                 yscroll,
        output logic                       csel,
        output logic                       rsel,
        output logic                       den,
        output logic                       bmm,
        output logic                       ecm,
        output logic                       res,
        output logic                       mcm,
        output vic_regs_pkg::raster_t      raster_irq_compare,
        output logic [2:0]                 cb,
        output logic [3:0]                 vm,
        output logic                       irst_clr,
        output logic                       imbc_clr,
        output logic                       immc_clr,
        output logic                       ilp_clr,
        output logic                       erst,
        output logic                       embc,
        output logic                       emmc,
        output logic                       elp
);

        logic wr_stb;
        logic rd_en;
        vic_regs_pkg::data_t disp_rd_data;
        vic_regs_pkg::data_t color_rd_data;
        vic_regs_pkg::data_t irq_rd_data;
        logic disp_rd_hit;
        logic color_rd_hit;
        logic irq_rd_hit;

        bus_timing #(
                .dav_tick(dav_tick)
        ) u_bus_timing (
                .clk_dot4x(clk_dot4x), .rst(rst), .ce(ce), .rw(rw),
                .vic_write_ab(vic_write_ab), .clk_phi(clk_phi),
                .phase_15(phase_15), .wr_stb(wr_stb), .rd_en(rd_en)
        );

        display_ctrl_regs u_display_ctrl_regs (
                .clk_dot4x(clk_dot4x), .rst(rst), .wr_stb(wr_stb), .adi(adi), .dbi(dbi),
                .raster_line(raster_line), .lpx(lpx), .lpy(lpy),
                .rd_data(disp_rd_data), .rd_hit(disp_rd_hit),
                .xscroll(xscroll), .yscroll(yscroll), .csel(csel), .rsel(rsel),
                .den(den), .bmm(bmm), .ecm(ecm), .res(res), .mcm(mcm),
                .raster_irq_compare(raster_irq_compare), .cb(cb), .vm(vm)
        );

        color_regs u_color_regs (
                .clk_dot4x(clk_dot4x), .rst(rst), .wr_stb(wr_stb), .adi(adi), .dbi(dbi),
                .rd_data(color_rd_data), .rd_hit(color_rd_hit),
                .ec(ec), .bg_color(bg_color)
        );

        irq_ctrl_regs u_irq_ctrl_regs (
                .clk_dot4x(clk_dot4x), .rst(rst), .clk_phi(clk_phi),
                .phase_15(phase_15), .wr_stb(wr_stb), .adi(adi), .dbi(dbi),
                .irq(irq), .ilp(ilp), .immc(immc), .imbc(imbc), .irst(irst),
                .rd_data(irq_rd_data), .rd_hit(irq_rd_hit),
                .irst_clr(irst_clr), .imbc_clr(imbc_clr),
                .immc_clr(immc_clr), .ilp_clr(ilp_clr),
                .erst(erst), .embc(embc), .emmc(emmc), .elp(elp)
        );

        reg_read_mux u_reg_read_mux (
                .clk_dot4x(clk_dot4x), .rst(rst), .rd_en(rd_en),
                .disp_rd_data(disp_rd_data), .disp_rd_hit(disp_rd_hit),
                .color_rd_data(color_rd_data), .color_rd_hit(color_rd_hit),
                .irq_rd_data(irq_rd_data), .irq_rd_hit(irq_rd_hit),
                .dbo(dbo)
        );

endmodule

`default_nettype wire

/* logic/reg_read_mux.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_read_mux (
        input  wire                    clk_dot4x,
        input  wire                    rst,
        input  wire                    rd_en,
        input  vic_regs_pkg::data_t    disp_rd_data,
        input  wire                    disp_rd_hit,
        input  vic_regs_pkg::data_t    color_rd_data,
        input  wire                    color_rd_hit,
        input  vic_regs_pkg::data_t    irq_rd_data,
        input  wire                    irq_rd_hit,
        output vic_regs_pkg::data_t    dbo
);

        vic_regs_pkg::data_t sel_data;

        // address ranges never overlap, order is arbitrary
        always_comb begin
                if (disp_rd_hit) begin
                        sel_data = disp_rd_data;
                end else if (color_rd_hit) begin
                        sel_data = color_rd_data;
                end else if (irq_rd_hit) begin
                        sel_data = irq_rd_data;
                end else begin
                        // unmapped
                        sel_data = 8'hff;
                end
        end

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        dbo <= '0;
                end else if (rd_en) begin
                        dbo <= sel_data;
                end
        end

endmodule

`default_nettype wire

/* logic/irq_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module irq_ctrl_regs (
        input  wire                        clk_dot4x,
        input  wire                        rst,
        input  wire                        clk_phi,
        input  wire                        phase_15,
        input  wire                        wr_stb,
        input  vic_regs_pkg::reg_addr_t    adi,
        input  vic_regs_pkg::data_t        dbi,
        input  wire                        irq,
        input  wire                        ilp,
        input  wire                        immc,
        input  wire                        imbc,
        input  wire                        irst,
        output vic_regs_pkg::data_t        rd_data,
        output logic                       rd_hit,
        output logic                       irst_clr,
        output logic                       imbc_clr,
        output logic                       immc_clr,
        output logic                       ilp_clr,
        output logic                       erst,
        output logic                       embc,
        output logic                       emmc,
        output logic                       elp
);

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        {ilp_clr, immc_clr, imbc_clr, irst_clr} <= '0;
                        {elp, emmc, embc, erst} <= '0;
                end else begin
                        // clear pulses end on the last tick of the high phase
                        if (phase_15 && clk_phi) begin
                                {ilp_clr, immc_clr, imbc_clr, irst_clr} <= '0;
                        end
                        if (wr_stb) begin
                                case (adi)
                                        vic_regs_pkg::REG_INTERRUPT_STATUS:
                                                {ilp_clr, immc_clr, imbc_clr, irst_clr} <= dbi[3:0];
                                        vic_regs_pkg::REG_INTERRUPT_CONTROL:
                                                {elp, emmc, embc, erst} <= dbi[3:0];
                                        default: ;
                                endcase
                        end
                end
        end

        always_comb begin
                rd_hit = 1'b1;
                case (adi)
                        // irq comes in already inverted
                        vic_regs_pkg::REG_INTERRUPT_STATUS:
                                rd_data = {irq, 3'b111, ilp, immc, imbc, irst};
                        vic_regs_pkg::REG_INTERRUPT_CONTROL:
                                rd_data = {4'b1111, elp, emmc, embc, erst};
                        default: begin
                                rd_hit = 1'b0;
                                rd_data = 8'hff;
                        end
                endcase
        end

endmodule

`default_nettype wire

/* logic/color_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module color_regs (
        input  wire                        clk_dot4x,
        input  wire                        rst,
        input  wire                        wr_stb,
        input  vic_regs_pkg::reg_addr_t    adi,
        input  vic_regs_pkg::data_t        dbi,
        output vic_regs_pkg::data_t        rd_data,
        output logic                       rd_hit,
        output vic_regs_pkg::vic_color_t   ec,
        output vic_regs_pkg::vic_color_t   bg_color [vic_regs_pkg::NUM_BG_COLORS]
);

        // entry 0 is the border, 1..4 the backgrounds
        vic_regs_pkg::vic_color_t col [0:vic_regs_pkg::NUM_BG_COLORS];
        logic [5:0] offs;

        // offset from 0x20, wraps high for lower addresses
        assign offs = 6'(adi - vic_regs_pkg::REG_BORDER_COLOR);
        assign rd_hit = (offs <= 6'(vic_regs_pkg::NUM_BG_COLORS));

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        for (int i = 0; i <= vic_regs_pkg::NUM_BG_COLORS; i++) begin
                                col[i] <= vic_regs_pkg::BLACK;
                        end
                end else if (wr_stb && rd_hit) begin
                        col[offs[2:0]] <= vic_regs_pkg::vic_color_t'(dbi[3:0]);
                end
        end

        // upper nibble is not stored
        assign rd_data = rd_hit ? {4'hf, col[offs[2:0]]} : 8'hff;

        assign ec = col[0];

        for (genvar g = 0; g < vic_regs_pkg::NUM_BG_COLORS; g++) begin : g_bg
                assign bg_color[g] = col[g + 1];
        end

endmodule

`default_nettype wire

/* logic/display_ctrl_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module display_ctrl_regs (
        input  wire                        clk_dot4x,
        input  wire                        rst,
        input  wire                        wr_stb,
        input  vic_regs_pkg::reg_addr_t    adi,
        input  vic_regs_pkg::data_t        dbi,
        input  vic_regs_pkg::raster_t      raster_line,
        input  vic_regs_pkg::data_t        lpx,
        input  vic_regs_pkg::data_t        lpy,
        output vic_regs_pkg::data_t        rd_data,
        output logic                       rd_hit,
        output logic [2:0]                 xscroll,
        output logic [2:0]                 yscroll,
        output logic                       csel,
        output logic                       rsel,
        output logic                       den,
        output logic                       bmm,
        output logic                       ecm,
        output logic                       res,
        output logic                       mcm,
        output vic_regs_pkg::raster_t      raster_irq_compare,
        output logic [2:0]                 cb,
        output logic [3:0]                 vm
);

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        {ecm, bmm, den, rsel, yscroll} <= '0;
                        {res, mcm, csel, xscroll} <= '0;
                        raster_irq_compare <= '0;
                        cb <= '0;
                        vm <= '0;
                end else if (wr_stb) begin
                        case (adi)
                                vic_regs_pkg::REG_SCREEN_CONTROL_1: begin
                                        // bit 7 goes to the compare, not to the line counter
                                        raster_irq_compare[8] <= dbi[7];
                                        {ecm, bmm, den, rsel, yscroll} <= dbi[6:0];
                                end
                                vic_regs_pkg::REG_RASTER_LINE: begin
                                        raster_irq_compare[7:0] <= dbi;
                                end
                                vic_regs_pkg::REG_SCREEN_CONTROL_2: begin
                                        {res, mcm, csel, xscroll} <= dbi[5:0];
                                end
                                vic_regs_pkg::REG_MEMORY_SETUP: begin
                                        vm <= dbi[7:4];
                                        cb <= dbi[3:1];
                                end
                                default: ;
                        endcase
                end
        end

        // read side shows the live raster line, not the compare value
        always_comb begin
                rd_hit = 1'b1;
                case (adi)
                        vic_regs_pkg::REG_SCREEN_CONTROL_1:
                                rd_data = {raster_line[8], ecm, bmm, den, rsel, yscroll};
                        vic_regs_pkg::REG_RASTER_LINE: rd_data = raster_line[7:0];
                        vic_regs_pkg::REG_LIGHT_PEN_X: rd_data = lpx;
                        vic_regs_pkg::REG_LIGHT_PEN_Y: rd_data = lpy;
                        vic_regs_pkg::REG_SCREEN_CONTROL_2:
                                rd_data = {2'b11, res, mcm, csel, xscroll};
                        vic_regs_pkg::REG_MEMORY_SETUP: rd_data = {vm, cb, 1'b1};
                        default: begin
                                rd_hit = 1'b0;
                                rd_data = 8'hff;
                        end
                endcase
        end

endmodule

`default_nettype wire

/* logic/bus_timing.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_timing #(
        parameter int dav_tick = 28
) (
        input  wire  clk_dot4x,
        input  wire  rst,
        input  wire  ce,
        input  wire  rw,
        input  wire  vic_write_ab,
        output logic clk_phi,
        output logic phase_15,
        output logic wr_stb,
        output logic rd_en
);

        vic_regs_pkg::phase_cnt_t cnt;
        logic cpu_access;
        logic wr_access;
        // write access held without a break since tick 16
        logic acc_armed;

        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        cnt <= '0;
                end else if (cnt == vic_regs_pkg::phase_cnt_t'(vic_regs_pkg::PHASE_TICKS - 1)) begin
                        cnt <= '0;
                end else begin
                        cnt <= cnt + 1'b1;
                end
        end

        // low phase is ticks 0..15, high phase 16..31
        assign clk_phi = cnt[4];
        assign phase_15 = (cnt[3:0] == 4'd15);

        assign cpu_access = !ce && !vic_write_ab;
        assign wr_access = cpu_access && !rw;
        assign rd_en = cpu_access && rw;

        // armed on the last low tick, dropped as soon as the access goes away
        always_ff @(posedge clk_dot4x) begin
                if (rst) begin
                        acc_armed <= 1'b0;
                end else if (phase_15 && !clk_phi) begin
                        acc_armed <= 1'b1;
                end else begin
                        acc_armed <= acc_armed && wr_access;
                end
        end

        assign wr_stb = acc_armed && wr_access && clk_phi &&
                        (cnt == vic_regs_pkg::phase_cnt_t'(dav_tick));

endmodule

`default_nettype wire

/* logic/vic_regs_pkg.sv */
`default_nettype none

package vic_regs_pkg;

        // phi cycle length in dot4x ticks
        localparam int PHASE_TICKS = 32;
        localparam int NUM_BG_COLORS = 4;

        typedef logic [7:0] data_t;
        typedef logic [8:0] raster_t;
        typedef logic [4:0] phase_cnt_t;

        // standard 16 entry palette
        typedef enum logic [3:0] {
                BLACK       = 4'h0,
                WHITE       = 4'h1,
                RED         = 4'h2,
                CYAN        = 4'h3,
                PURPLE      = 4'h4,
                GREEN       = 4'h5,
                BLUE        = 4'h6,
                YELLOW      = 4'h7,
                ORANGE      = 4'h8,
                BROWN       = 4'h9,
                PINK        = 4'ha,
                DARK_GREY   = 4'hb,
                GREY        = 4'hc,
                LIGHT_GREEN = 4'hd,
                LIGHT_BLUE  = 4'he,
                LIGHT_GREY  = 4'hf
        } vic_color_t;

        // offsets of the mapped registers
        typedef enum logic [5:0] {
                REG_SCREEN_CONTROL_1   = 6'h11,
                REG_RASTER_LINE        = 6'h12,
                REG_LIGHT_PEN_X        = 6'h13,
                REG_LIGHT_PEN_Y        = 6'h14,
                REG_SCREEN_CONTROL_2   = 6'h16,
                REG_MEMORY_SETUP       = 6'h18,
                REG_INTERRUPT_STATUS   = 6'h19,
                REG_INTERRUPT_CONTROL  = 6'h1a,
                REG_BORDER_COLOR       = 6'h20,
                REG_BACKGROUND_COLOR_0 = 6'h21,
                REG_BACKGROUND_COLOR_1 = 6'h22,
                REG_BACKGROUND_COLOR_2 = 6'h23,
                REG_BACKGROUND_COLOR_3 = 6'h24
        } reg_addr_t;

endpackage

`default_nettype wire
